//--- hdl/store_pkg.sv
package store_pkg;

    // word size of the store datapath
    localparam int DATA_WIDTH = 32;

    // store opcodes accepted from the pipeline
    typedef enum logic [1:0] {
        SB,
        SH,
        SW
    } store_op_t;

    // access width, one per opcode
    typedef enum logic [1:0] {
        BYTE,
        HALF_WORD,
        WORD
    } store_width_t;

    // reported with done when the store did not complete
    typedef enum logic [1:0] {
        NO_FAULT,
        ACCESS_FAULT,
        MISALIGNED,
        BUS_TIMEOUT
    } fault_cause_t;

    // one store word, seen as byte lanes or as half-word lanes
    typedef union packed {
        logic [DATA_WIDTH/8-1:0][7:0]   bytes;
        logic [DATA_WIDTH/16-1:0][15:0] halves;
    } store_word_u;

    // opcode to access width
    function automatic store_width_t width_of(input store_op_t op);
        store_width_t width;

        case (op)
            SB: begin
                width = BYTE;
            end
            SH: begin
                width = HALF_WORD;
            end
            default: begin
                width = WORD;
            end
        endcase
        return width;
    endfunction

endpackage : store_pkg

//--- hdl/store_region_check.sv
module store_region_check #(
    parameter logic [store_pkg::DATA_WIDTH-1:0] BOOT_END = 32'h0000_0FFF,
    parameter logic [store_pkg::DATA_WIDTH-1:0] IO_END   = 32'h0000_FFFF
) (
    input  logic [store_pkg::DATA_WIDTH-1:0] addr_i,
    input  store_pkg::store_op_t             op_i,
    output logic                             accessible_o,
    output logic                             cachable_o,
    output logic                             bufferable_o,
    output logic                             misaligned_o
);

    logic half_odd;
    logic word_unaligned;

    // boot region is read only
    assign accessible_o = addr_i > BOOT_END;

    // above the IO window memory may be cached and buffered
    assign cachable_o   = addr_i > IO_END;
    assign bufferable_o = addr_i > IO_END;

    // half-words need an even address, words a multiple of four
    assign half_odd       = (op_i == store_pkg::SH) && addr_i[0];
    assign word_unaligned = (op_i == store_pkg::SW) && (addr_i[1:0] != 2'b00);

    assign misaligned_o = half_odd || word_unaligned;

endmodule : store_region_check

//--- hdl/store_lane_align.sv
module store_lane_align (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             load_i,
    input  logic [store_pkg::DATA_WIDTH-1:0] addr_i,
    input  logic [store_pkg::DATA_WIDTH-1:0] data_i,
    input  store_pkg::store_op_t             op_i,
    input  logic                             cachable_i,
    input  logic                             bufferable_i,
    output logic [store_pkg::DATA_WIDTH-1:0] mem_addr_o,
    output logic [store_pkg::DATA_WIDTH-1:0] mem_wdata_o,
    output logic [3:0]                       mem_be_o,
    output logic                             mem_cachable_o,
    output logic                             mem_bufferable_o
);

    store_pkg::store_width_t width;
    store_pkg::store_word_u  word_in;
    store_pkg::store_word_u  word_rep;
    logic [3:0]              be;

    assign width   = store_pkg::width_of(op_i);
    assign word_in = data_i;

    // copy the low byte or half-word into every lane of its size
    always_comb begin
        word_rep = word_in;
        case (width)
            store_pkg::BYTE: begin
                for (int i = 0; i < store_pkg::DATA_WIDTH / 8; i++) begin
                    word_rep.bytes[i] = word_in.bytes[0];
                end
            end
            store_pkg::HALF_WORD: begin
                for (int i = 0; i < store_pkg::DATA_WIDTH / 16; i++) begin
                    word_rep.halves[i] = word_in.halves[0];
                end
            end
            default: begin
                word_rep = word_in;
            end
        endcase
    end

    // lane select from the low address bits
    always_comb begin
        case (width)
            store_pkg::BYTE:      be = 4'b0001 << addr_i[1:0];
            store_pkg::HALF_WORD: be = addr_i[1] ? 4'b1100 : 4'b0011;
            store_pkg::WORD:      be = 4'b1111;
            default:              be = 4'b0000;
        endcase
    end

    // request payload, held stable for the whole handshake
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            mem_addr_o  <= {addr_i[store_pkg::DATA_WIDTH-1:2], 2'b00};
            mem_wdata_o <= word_rep;
            mem_be_o    <= be;
        end
    end

    // attributes come out of reset as uncached IO
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_cachable_o   <= 1'b0;
            mem_bufferable_o <= 1'b0;
        end else if (load_i) begin
            mem_cachable_o   <= cachable_i;
            mem_bufferable_o <= bufferable_i;
        end
    end

    // a loaded request carries one of the legal lane patterns
    be_legal_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_i |=> mem_be_o inside {4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                    4'b0011, 4'b1100, 4'b1111});

endmodule : store_lane_align

//--- hdl/store_timeout_counter.sv
module store_timeout_counter #(
    parameter int TIMEOUT_CYCLES = 16
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic count_en_i,
    output logic expired_o
);

    // wide enough to hold TIMEOUT_CYCLES itself
    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] count_q;
    logic             at_limit;

    assign at_limit = (count_q == CNT_W'(TIMEOUT_CYCLES - 1));

    // restarts from zero every time the enable drops
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (!count_en_i) begin
            count_q <= '0;
        end else if (!at_limit) begin
            count_q <= count_q + 1'b1;
        end
    end

    // only meaningful while a request is outstanding
    assign expired_o = count_en_i && at_limit;

endmodule : store_timeout_counter

//--- hdl/store_fsm.sv
module store_fsm (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    valid_i,
    input  logic                    accessible_i,
    input  logic                    misaligned_i,
    input  logic                    mem_ack_i,
    input  logic                    expired_i,
    input  logic                    accepted_i,
    output logic                    idle_o,
    output logic                    load_o,
    output logic                    mem_req_o,
    output logic                    count_en_o,
    output logic                    done_o,
    output logic                    fault_o,
    output store_pkg::fault_cause_t fault_cause_o
);

    localparam logic [2:0] IDLE    = 3'd0;
    localparam logic [2:0] REQUEST = 3'd1;
    localparam logic [2:0] RELEASE = 3'd2;
    localparam logic [2:0] COMMIT  = 3'd3;
    localparam logic [2:0] FAULT   = 3'd4;

    logic [2:0]              state_q;
    logic [2:0]              state_d;
    store_pkg::fault_cause_t cause_q;
    store_pkg::fault_cause_t cause_d;
    logic                    accept;

    assign accept = idle_o && valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cause_q <= store_pkg::NO_FAULT;
        end else begin
            state_q <= state_d;
            cause_q <= cause_d;
        end
    end

    always_comb begin
        state_d = state_q;
        cause_d = cause_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    // access fault wins over misalignment
                    if (!accessible_i) begin
                        state_d = FAULT;
                        cause_d = store_pkg::ACCESS_FAULT;
                    end else if (misaligned_i) begin
                        state_d = FAULT;
                        cause_d = store_pkg::MISALIGNED;
                    end else begin
                        state_d = REQUEST;
                        cause_d = store_pkg::NO_FAULT;
                    end
                end
            end
            REQUEST: begin
                // a late ack in the expiry cycle still completes the store
                if (mem_ack_i) begin
                    state_d = RELEASE;
                end else if (expired_i) begin
                    state_d = FAULT;
                    cause_d = store_pkg::BUS_TIMEOUT;
                end
            end
            RELEASE: begin
                // controller closes the four-phase cycle
                if (!mem_ack_i) begin
                    state_d = COMMIT;
                end
            end
            COMMIT, FAULT: begin
                // result held until the pipeline takes it
                if (accepted_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign idle_o        = (state_q == IDLE);
    assign load_o        = accept;
    assign mem_req_o     = (state_q == REQUEST);
    assign count_en_o    = (state_q == REQUEST);
    assign done_o        = (state_q == COMMIT) || (state_q == FAULT);
    assign fault_o       = (state_q == FAULT);
    assign fault_cause_o = cause_q;

    // req is only withdrawn by an ack or by the timer
    req_held_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o && !mem_ack_i && !expired_i |=> mem_req_o);

    // the handshake is fully closed whenever a result is shown
    done_quiet_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_o |-> !mem_req_o && !mem_ack_i);

endmodule : store_fsm

//--- hdl/store_unit.sv
module store_unit #(
    parameter logic [store_pkg::DATA_WIDTH-1:0] BOOT_END       = 32'h0000_0FFF,
    parameter logic [store_pkg::DATA_WIDTH-1:0] IO_END         = 32'h0000_FFFF,
    parameter int                               TIMEOUT_CYCLES = 16
) (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             valid_i,
    input  store_pkg::store_op_t             op_i,
    input  logic [store_pkg::DATA_WIDTH-1:0] addr_i,
    input  logic [store_pkg::DATA_WIDTH-1:0] data_i,
    input  logic                             accepted_i,
    input  logic                             mem_ack_i,
    output logic                             idle_o,
    output logic                             done_o,
    output logic                             fault_o,
    output store_pkg::fault_cause_t          fault_cause_o,
    output logic                             mem_req_o,
    output logic [store_pkg::DATA_WIDTH-1:0] mem_addr_o,
    output logic [store_pkg::DATA_WIDTH-1:0] mem_wdata_o,
    output logic [3:0]                       mem_be_o,
    output logic                             mem_cachable_o,
    output logic                             mem_bufferable_o
);

    logic accessible;
    logic cachable;
    logic bufferable;
    logic misaligned;
    logic load;
    logic count_en;
    logic expired;

    // address classification on the incoming store
    store_region_check #(
        .BOOT_END (BOOT_END),
        .IO_END   (IO_END)
    ) region0 (
        .addr_i       (addr_i),
        .op_i         (op_i),
        .accessible_o (accessible),
        .cachable_o   (cachable),
        .bufferable_o (bufferable),
        .misaligned_o (misaligned)
    );

    store_lane_align align0 (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .load_i           (load),
        .addr_i           (addr_i),
        .data_i           (data_i),
        .op_i             (op_i),
        .cachable_i       (cachable),
        .bufferable_i     (bufferable),
        .mem_addr_o       (mem_addr_o),
        .mem_wdata_o      (mem_wdata_o),
        .mem_be_o         (mem_be_o),
        .mem_cachable_o   (mem_cachable_o),
        .mem_bufferable_o (mem_bufferable_o)
    );

    // guards against a controller that never answers
    store_timeout_counter #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) timer0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .count_en_i (count_en),
        .expired_o  (expired)
    );

    store_fsm fsm0 (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .valid_i       (valid_i),
        .accessible_i  (accessible),
        .misaligned_i  (misaligned),
        .mem_ack_i     (mem_ack_i),
        .expired_i     (expired),
        .accepted_i    (accepted_i),
        .idle_o        (idle_o),
        .load_o        (load),
        .mem_req_o     (mem_req_o),
        .count_en_o    (count_en),
        .done_o        (done_o),
        .fault_o       (fault_o),
        .fault_cause_o (fault_cause_o)
    );

endmodule : store_unit

//--- testbench/tb_store_mem_model.sv
module tb_store_mem_model (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        mute_i,
    input  int unsigned delay_i,
    input  logic        req_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  be_i,
    output logic        ack_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // sparse byte store, filled only by acknowledged writes
    logic [7:0]  mem [logic [31:0]];
    int unsigned wait_q;

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        return {mem[addr + 3], mem[addr + 2], mem[addr + 1], mem[addr]};
    endfunction

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_o  <= 1'b0;
            wait_q <= 0;
        end else if (ack_o) begin
            // four-phase return to zero
            if (!req_i) begin
                ack_o <= 1'b0;
            end
        end else if (req_i && !mute_i) begin
            if (wait_q >= delay_i) begin
                ack_o  <= 1'b1;
                wait_q <= 0;
                for (int unsigned i = 0; i < 4; i++) begin
                    if (be_i[i]) begin
                        mem[addr_i + i] = wdata_i[8*i +: 8];
                    end
                end
            end else begin
                wait_q <= wait_q + 1;
            end
        end else begin
            wait_q <= 0;
        end
    end

endmodule : tb_store_mem_model

//--- testbench/tb_store_unit.sv
module tb_store_unit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] BOOT_END       = 32'h0000_0FFF;
    localparam logic [31:0] IO_END         = 32'h0000_FFFF;
    localparam int          TIMEOUT_CYCLES = 16;
    localparam int          N_WORD         = 10;
    localparam int          N_HOLD         = 6;
    // reset, then a rough budget per test, plus a wide margin
    localparam int MAX_CYCLES = 16 + 30 * N_WORD + 40 * 12 + 10 * 7
                              + 4 * TIMEOUT_CYCLES + 60 * N_HOLD + 3000;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    valid_i;
    store_pkg::store_op_t    op_i;
    logic [31:0]             addr_i;
    logic [31:0]             data_i;
    logic                    accepted_i;
    logic                    mem_ack_i;
    logic                    idle_o;
    logic                    done_o;
    logic                    fault_o;
    store_pkg::fault_cause_t fault_cause_o;
    logic                    mem_req_o;
    logic [31:0]             mem_addr_o;
    logic [31:0]             mem_wdata_o;
    logic [3:0]              mem_be_o;
    logic                    mem_cachable_o;
    logic                    mem_bufferable_o;
    logic                    mute;
    int unsigned             ack_delay;
    logic [31:0]             lfsr_q;
    int                      cycles = 0;

    store_unit #(
        .BOOT_END       (BOOT_END),
        .IO_END         (IO_END),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) dut0 (.*);

    tb_store_mem_model mem0 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .mute_i  (mute),
        .delay_i (ack_delay),
        .req_i   (mem_req_o),
        .addr_i  (mem_addr_o),
        .wdata_i (mem_wdata_o),
        .be_i    (mem_be_o),
        .ack_o   (mem_ack_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            abort_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_be(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_cause(input string name, input store_pkg::fault_cause_t got,
                               input store_pkg::fault_cause_t exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %s expected %s", $time, name,
                                got.name(), exp.name()));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // enabled lanes are the bytes that the store covers within its word
    function automatic logic [3:0] expected_be(input store_pkg::store_op_t op,
                                               input logic [31:0] addr);
        logic [3:0] be;
        be = '0;
        case (op)
            store_pkg::SB: begin
                be[addr[1:0]] = 1'b1;
            end
            store_pkg::SH: begin
                be[{addr[1], 1'b0}] = 1'b1;
                be[{addr[1], 1'b1}] = 1'b1;
            end
            default: begin
                be = 4'b1111;
            end
        endcase
        return be;
    endfunction

    function automatic logic [31:0] expected_wdata(input store_pkg::store_op_t op,
                                                   input logic [31:0] data);
        logic [31:0] w;
        case (op)
            store_pkg::SB: w = {4{data[7:0]}};
            store_pkg::SH: w = {2{data[15:0]}};
            default:       w = data;
        endcase
        return w;
    endfunction

    task automatic issue(input store_pkg::store_op_t op, input logic [31:0] addr,
                         input logic [31:0] data);
        @(posedge clk_i);
        valid_i <= 1'b1;
        op_i    <= op;
        addr_i  <= addr;
        data_i  <= data;
        @(posedge clk_i);
        valid_i <= 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!done_o) begin
            if (n == limit) begin
                abort_run("done_o did not rise while waiting for the store result");
            end else begin
                n++;
                @(negedge clk_i);
            end
        end
    endtask

    task automatic take_result();
        @(posedge clk_i);
        accepted_i <= 1'b1;
        @(posedge clk_i);
        accepted_i <= 1'b0;
        @(negedge clk_i);
        check_bit("idle_o", idle_o, 1'b1);
        check_bit("done_o", done_o, 1'b0);
    endtask

    task automatic store_and_check(input store_pkg::store_op_t op, input logic [31:0] addr,
                                   input logic [31:0] data);
        issue(op, addr, data);
        @(negedge clk_i);
        check_bit("mem_req_o", mem_req_o, 1'b1);
        check_word("mem_addr_o", mem_addr_o, addr & 32'hffff_fffc);
        check_word("mem_wdata_o", mem_wdata_o, expected_wdata(op, data));
        check_be("mem_be_o", mem_be_o, expected_be(op, addr));
        check_bit("mem_cachable_o", mem_cachable_o, addr > IO_END);
        check_bit("mem_bufferable_o", mem_bufferable_o, addr > IO_END);
        wait_done(64);
        check_bit("fault_o", fault_o, 1'b0);
        check_cause("fault_cause_o", fault_cause_o, store_pkg::NO_FAULT);
        take_result();
    endtask

    task automatic expect_fault(input store_pkg::store_op_t op, input logic [31:0] addr,
                                input store_pkg::fault_cause_t cause);
        issue(op, addr, rand_bits(32));
        @(negedge clk_i);
        check_bit("done_o", done_o, 1'b1);
        check_bit("fault_o", fault_o, 1'b1);
        check_cause("fault_cause_o", fault_cause_o, cause);
        check_bit("mem_req_o", mem_req_o, 1'b0);
        take_result();
    endtask

    task automatic word_store_test();
        logic [31:0] addr;
        logic [31:0] data;
        for (int k = 0; k < N_WORD; k++) begin
            addr = 32'h0010_0000 | (rand_bits(18) << 2);
            data = rand_bits(32);
            ack_delay <= rand_bits(3);
            store_and_check(store_pkg::SW, addr, data);
            check_word("memory word", mem0.read_word(addr), data);
        end
    endtask

    task automatic lane_store_test();
        store_pkg::store_op_t op;
        logic [31:0]          base;
        logic [31:0]          init;
        logic [31:0]          data;
        logic [31:0]          wdata;
        logic [31:0]          want;
        logic [3:0]           be;
        int                   off;
        // four byte offsets, then the two half-word offsets
        for (int k = 0; k < 6; k++) begin
            op   = (k < 4) ? store_pkg::SB : store_pkg::SH;
            off  = (k < 4) ? k : 2 * (k - 4);
            base = 32'h0000_1000 + (rand_bits(12) << 2);
            init = rand_bits(32);
            data = rand_bits(32);
            ack_delay <= rand_bits(2);
            store_and_check(store_pkg::SW, base, init);
            store_and_check(op, base + off, data);
            be    = expected_be(op, base + off);
            wdata = expected_wdata(op, data);
            want  = init;
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    want[8*i +: 8] = wdata[8*i +: 8];
                end
            end
            check_word("memory word", mem0.read_word(base), want);
        end
    endtask

    task automatic fault_test();
        expect_fault(store_pkg::SW, 32'h0000_0FFC, store_pkg::ACCESS_FAULT);
        expect_fault(store_pkg::SB, BOOT_END, store_pkg::ACCESS_FAULT);
        expect_fault(store_pkg::SH, rand_bits(11) << 1, store_pkg::ACCESS_FAULT);
        expect_fault(store_pkg::SH, (32'h1000 + (rand_bits(12) << 1)) | 32'h1,
                     store_pkg::MISALIGNED);
        expect_fault(store_pkg::SW, 32'h0010_0001, store_pkg::MISALIGNED);
        expect_fault(store_pkg::SW, 32'h0010_0002, store_pkg::MISALIGNED);
        expect_fault(store_pkg::SW, 32'h0000_2003, store_pkg::MISALIGNED);
    endtask

    task automatic timeout_test();
        int n;
        mute <= 1'b1;
        issue(store_pkg::SW, 32'h0030_0000 | (rand_bits(16) << 2), rand_bits(32));
        @(negedge clk_i);
        n = 0;
        while (mem_req_o && n < 4 * TIMEOUT_CYCLES) begin
            n++;
            @(negedge clk_i);
        end
        check_word("cycles with mem_req_o high", n, TIMEOUT_CYCLES);
        check_bit("done_o", done_o, 1'b1);
        check_bit("fault_o", fault_o, 1'b1);
        check_cause("fault_cause_o", fault_cause_o, store_pkg::BUS_TIMEOUT);
        take_result();
        mute <= 1'b0;
    endtask

    task automatic backpressure_test();
        store_pkg::fault_cause_t want;
        int                      hold;
        for (int k = 0; k < N_HOLD; k++) begin
            hold = rand_bits(4) + 1;
            if (k % 2 == 0) begin
                want = store_pkg::NO_FAULT;
                ack_delay <= rand_bits(2);
                issue(store_pkg::SW, 32'h0020_0000 | (rand_bits(16) << 2), rand_bits(32));
            end else begin
                want = store_pkg::ACCESS_FAULT;
                issue(store_pkg::SB, rand_bits(12), rand_bits(32));
            end
            @(negedge clk_i);
            wait_done(64);
            repeat (hold) begin
                check_bit("done_o", done_o, 1'b1);
                check_cause("fault_cause_o", fault_cause_o, want);
                check_bit("idle_o", idle_o, 1'b0);
                @(negedge clk_i);
            end
            take_result();
        end
    endtask

    initial begin
        lfsr_q     = 32'h44589efa;
        rst_n_i    = 1'b0;
        valid_i    = 1'b0;
        op_i       = store_pkg::SB;
        addr_i     = '0;
        data_i     = '0;
        accepted_i = 1'b0;
        mute       = 1'b0;
        ack_delay  = 0;
        repeat (16) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_bit("idle_o", idle_o, 1'b1);
        check_bit("mem_req_o", mem_req_o, 1'b0);
        check_bit("done_o", done_o, 1'b0);
        check_bit("fault_o", fault_o, 1'b0);
        word_store_test();
        lane_store_test();
        fault_test();
        timeout_test();
        backpressure_test();
        $display("TEST PASSED");
        $finish;
    end

endmodule : tb_store_unit

//--- store_unit.f
hdl/store_pkg.sv
hdl/store_region_check.sv
hdl/store_lane_align.sv
hdl/store_timeout_counter.sv
hdl/store_fsm.sv
hdl/store_unit.sv
testbench/tb_store_mem_model.sv
testbench/tb_store_unit.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_store_unit
FILELIST := store_unit.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
